//--- logic/clct_pkg.sv
package clct_pkg;

  //--------------------------------------------------------------------------
  // Event geometry
  //--------------------------------------------------------------------------

  // Seven key groups of 32 half-strips each
  localparam int n_groups = 7;

  // Six CSC layers per candidate
  localparam int n_layers = 6;

  //--------------------------------------------------------------------------
  // Candidate field widths
  //--------------------------------------------------------------------------

  // Pattern id
  // Bits 6..4 hold the layer-hit count
  // Bits 3..1 hold the pattern number
  // Bit 0 gives the bend direction
  localparam int mxpatb  = 7;

  // Layer-hit count field at the top of the pattern id
  localparam int mxhitb  = 3;

  // Local key half-strip inside one group
  localparam int mxkeyb  = 5;

  // Global key is group index over local key
  localparam int mxkeybx = 8;

  // Comparator code with six 2-bit layer positions, layer 0 lowest
  localparam int mxpatc  = 12;
  localparam int mxposb  = 2;

  // Signed quarter-strip offset
  localparam int mxoffsb = 4;

  // Bend is direction bit over a 4-bit magnitude
  localparam int mxbndb  = 5;

  // Fit quality
  localparam int mxqltb  = 6;

  // Quarter-strip subkey
  localparam int mxxkyb  = 10;

  //--------------------------------------------------------------------------
  // Subkey sections
  //--------------------------------------------------------------------------

  // Keys 0 to 127 map into 0..511
  localparam int sect0_max_subkey = 511;

  // Keys 128 to 223 map into 512..895
  localparam int sect1_min_subkey = 512;
  localparam int sect1_max_subkey = 895;

endpackage

//--- logic/pattern_fit_lut.sv
`timescale 1ns/100ps

module pattern_fit_lut
  import clct_pkg::*;
(
  input  logic               clock,
  input  logic               reset,
  input  logic               in_strobe,
  input  logic [mxpatb-1:0]  pat       [n_groups],
  input  logic [mxkeyb-1:0]  key       [n_groups],
  input  logic [mxpatc-1:0]  carry     [n_groups],
  output logic               fit_strobe,
  output logic [mxpatb-1:0]  fit_pat   [n_groups],
  output logic [mxkeyb-1:0]  fit_key   [n_groups],
  output logic [mxpatc-1:0]  fit_carry [n_groups],
  output logic [mxoffsb-1:0] fit_offs  [n_groups],
  output logic [mxbndb-1:0]  fit_bend  [n_groups],
  output logic [mxqltb-1:0]  fit_qlt   [n_groups]
);

  // Position sum is centred on half the full-scale sum (6 layers x 3)
  localparam int pos_max     = (1 << mxposb) - 1;
  localparam int offs_center = n_layers * pos_max / 2;

  // Signed offset range
  localparam int offs_min = -(1 << (mxoffsb - 1));
  localparam int offs_max = (1 << (mxoffsb - 1)) - 1;

  //--------------------------------------------------------------------------
  // Per-group fit
  //--------------------------------------------------------------------------

  for (genvar g = 0; g < n_groups; g++)
  begin : gen_group
    logic [mxposb-1:0]   p [n_layers];
    logic [3:0]          sum_lo;
    logic [3:0]          sum_hi;
    logic [4:0]          p_sum;
    logic [mxposb-1:0]   p_max;
    logic [mxposb-1:0]   p_min;
    logic [mxhitb-1:0]   hits;
    logic [mxoffsb-1:0]  offs_c;
    logic [mxbndb-2:0]   bend_mag;
    logic [mxqltb-1:0]   qlt_c;

    // Split the comparator code into layer positions
    always_comb
    begin
      for (int i = 0; i < n_layers; i++)
        p[i] = carry[g][mxposb*i +: mxposb];
    end

    // Lower three and upper three layers
    always_comb
    begin
      sum_lo = 4'(p[0]) + 4'(p[1]) + 4'(p[2]);
      sum_hi = 4'(p[3]) + 4'(p[4]) + 4'(p[5]);
      p_sum  = 5'(sum_lo) + 5'(sum_hi);
    end

    // Offset from centred sum, clipped to 4-bit signed
    always_comb
    begin
      int offs_full;
      offs_full = int'(p_sum) - offs_center;
      if (offs_full < offs_min)
        offs_c = mxoffsb'(offs_min);
      else if (offs_full > offs_max)
        offs_c = mxoffsb'(offs_max);
      else
        offs_c = mxoffsb'(offs_full);
    end

    // Bend magnitude is |upper - lower|
    assign bend_mag = (sum_hi >= sum_lo) ? (sum_hi - sum_lo) : (sum_lo - sum_hi);

    // Spread of positions across layers
    always_comb
    begin
      p_max = p[0];
      p_min = p[0];
      for (int i = 1; i < n_layers; i++)
      begin
        if (p[i] > p_max)
          p_max = p[i];
        if (p[i] < p_min)
          p_min = p[i];
      end
    end

    // Quality = 8*hits + 7 - spread, forced to 0 with no hits
    assign hits  = pat[g][mxpatb-1 -: mxhitb];
    assign qlt_c = (hits == '0) ? '0 : ({hits, 3'b111} - mxqltb'(p_max - p_min));

    // Stage register, loads only with an event
    always_ff @(posedge clock)
    begin
      if (reset)
      begin
        fit_pat[g]   <= '0;
        fit_key[g]   <= '0;
        fit_carry[g] <= '0;
        fit_offs[g]  <= '0;
        fit_bend[g]  <= '0;
        fit_qlt[g]   <= '0;
      end
      else if (in_strobe)
      begin
        fit_pat[g]   <= pat[g];
        fit_key[g]   <= key[g];
        fit_carry[g] <= carry[g];
        fit_offs[g]  <= offs_c;
        fit_bend[g]  <= {pat[g][0], bend_mag};
        fit_qlt[g]   <= qlt_c;
      end
    end
  end

  // Event strobe, one cycle behind the input
  always_ff @(posedge clock)
  begin
    if (reset)
      fit_strobe <= 1'b0;
    else
      fit_strobe <= in_strobe;
  end

endmodule

//--- logic/candidate_buffer.sv
`timescale 1ns/100ps

module candidate_buffer
  import clct_pkg::*;
(
  input  logic               clock,
  input  logic               reset,
  input  logic               fit_strobe,
  input  logic [n_groups-1:0] group_enable,
  input  logic [mxpatb-1:0]  fit_pat   [n_groups],
  input  logic [mxkeyb-1:0]  fit_key   [n_groups],
  input  logic [mxpatc-1:0]  fit_carry [n_groups],
  input  logic [mxoffsb-1:0] fit_offs  [n_groups],
  input  logic [mxbndb-1:0]  fit_bend  [n_groups],
  input  logic [mxqltb-1:0]  fit_qlt   [n_groups],
  output logic               buf_strobe,
  output logic [mxpatb-1:0]  buf_pat   [n_groups],
  output logic [mxkeyb-1:0]  buf_key   [n_groups],
  output logic [mxpatc-1:0]  buf_carry [n_groups],
  output logic [mxoffsb-1:0] buf_offs  [n_groups],
  output logic [mxbndb-1:0]  buf_bend  [n_groups],
  output logic [mxqltb-1:0]  buf_qlt   [n_groups]
);

  //--------------------------------------------------------------------------
  // Pipeline cut between fit and sort
  //--------------------------------------------------------------------------

  // Enable is sampled as the event enters, not when it was fitted
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int g = 0; g < n_groups; g++)
      begin
        buf_pat[g]   <= '0;
        buf_key[g]   <= '0;
        buf_carry[g] <= '0;
        buf_offs[g]  <= '0;
        buf_bend[g]  <= '0;
        buf_qlt[g]   <= '0;
      end
    end
    else if (fit_strobe)
    begin
      for (int g = 0; g < n_groups; g++)
      begin
        // Disabled group loses every sort with zero pattern and quality
        buf_pat[g]   <= group_enable[g] ? fit_pat[g] : '0;
        buf_qlt[g]   <= group_enable[g] ? fit_qlt[g] : '0;
        // Geometry passes through untouched
        buf_key[g]   <= fit_key[g];
        buf_carry[g] <= fit_carry[g];
        buf_offs[g]  <= fit_offs[g];
        buf_bend[g]  <= fit_bend[g];
      end
    end
  end

  // Strobe follows fit by one cycle
  always_ff @(posedge clock)
  begin
    if (reset)
      buf_strobe <= 1'b0;
    else
      buf_strobe <= fit_strobe;
  end

endmodule

//--- logic/best_1of7_cclut.sv
`timescale 1ns/100ps

module best_1of7_cclut
  import clct_pkg::*;
#(
  parameter int sort_on_quality = 1
)
(
  input  logic                clock,
  input  logic                reset,
  input  logic                buf_strobe,
  input  logic [mxpatb-1:0]   buf_pat   [n_groups],
  input  logic [mxkeyb-1:0]   buf_key   [n_groups],
  input  logic [mxpatc-1:0]   buf_carry [n_groups],
  input  logic [mxoffsb-1:0]  buf_offs  [n_groups],
  input  logic [mxbndb-1:0]   buf_bend  [n_groups],
  input  logic [mxqltb-1:0]   buf_qlt   [n_groups],
  output logic                best_strobe,
  output logic [mxpatb-1:0]   best_pat,
  output logic [mxkeybx-1:0]  best_key,
  output logic [mxbndb-1:0]   best_bend,
  output logic [mxpatc-1:0]   best_carry,
  output logic [mxxkyb-1:0]   best_subkey,
  output logic [mxqltb-1:0]   best_qlt
);

  // Group index bits at the top of the global key
  localparam int grp_w = mxkeybx - mxkeyb;

  logic [mxqltb-1:0]  sort_key [n_groups];
  logic [grp_w-1:0]   win_grp;
  logic [mxqltb-1:0]  win_sort;
  logic [mxkeybx-1:0] win_key;
  logic [mxoffsb-1:0] win_offs;
  logic [mxxkyb-1:0]  subkey_c;

  //--------------------------------------------------------------------------
  // Sort key and winner
  //--------------------------------------------------------------------------

  // Post-fit quality, or the pattern without its bend bit
  always_comb
  begin
    for (int g = 0; g < n_groups; g++)
      sort_key[g] = (sort_on_quality != 0) ? buf_qlt[g] : buf_pat[g][mxpatb-1:1];
  end

  // Priority chain from group 0 upward
  // Only a strictly larger key displaces the holder, so ties stay low
  always_comb
  begin
    win_grp  = '0;
    win_sort = sort_key[0];
    for (int g = 1; g < n_groups; g++)
    begin
      if (sort_key[g] > win_sort)
      begin
        win_grp  = grp_w'(g);
        win_sort = sort_key[g];
      end
    end
  end

  // Global key is group index over local key
  assign win_key  = {win_grp, buf_key[win_grp]};
  assign win_offs = buf_offs[win_grp];

  //--------------------------------------------------------------------------
  // Quarter-strip subkey
  //--------------------------------------------------------------------------

  // 4*key + offset, then held inside the key's own section
  always_comb
  begin
    int raw;
    int lo;
    int hi;
    raw = 4 * int'(win_key) + int'($signed(win_offs));
    // Key 128 and up sets the global key msb
    if (win_key[mxkeybx-1])
    begin
      lo = sect1_min_subkey;
      hi = sect1_max_subkey;
    end
    else
    begin
      lo = 0;
      hi = sect0_max_subkey;
    end
    if (raw < lo)
      subkey_c = mxxkyb'(lo);
    else if (raw > hi)
      subkey_c = mxxkyb'(hi);
    else
      subkey_c = mxxkyb'(raw);
  end

  //--------------------------------------------------------------------------
  // Output register
  //--------------------------------------------------------------------------

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      best_pat    <= '0;
      best_key    <= '0;
      best_bend   <= '0;
      best_carry  <= '0;
      best_subkey <= '0;
      best_qlt    <= '0;
    end
    else if (buf_strobe)
    begin
      best_pat    <= buf_pat[win_grp];
      best_key    <= win_key;
      best_bend   <= buf_bend[win_grp];
      best_carry  <= buf_carry[win_grp];
      best_subkey <= subkey_c;
      best_qlt    <= buf_qlt[win_grp];
    end
  end

  // Result strobe
  always_ff @(posedge clock)
  begin
    if (reset)
      best_strobe <= 1'b0;
    else
      best_strobe <= buf_strobe;
  end

endmodule

//--- logic/clct_sorter.sv
`timescale 1ns/100ps

module clct_sorter
  import clct_pkg::*;
#(
  parameter int sort_on_quality = 1
)
(
  input  logic                clock,
  input  logic                reset,
  input  logic                in_strobe,
  input  logic [n_groups-1:0] group_enable,
  input  logic [mxpatb-1:0]   pat   [n_groups],
  input  logic [mxkeyb-1:0]   key   [n_groups],
  input  logic [mxpatc-1:0]   carry [n_groups],
  output logic                best_strobe,
  output logic [mxpatb-1:0]   best_pat,
  output logic [mxkeybx-1:0]  best_key,
  output logic [mxbndb-1:0]   best_bend,
  output logic [mxpatc-1:0]   best_carry,
  output logic [mxxkyb-1:0]   best_subkey,
  output logic [mxqltb-1:0]   best_qlt
);

  // Fit stage outputs
  logic               fit_strobe;
  logic [mxpatb-1:0]  fit_pat   [n_groups];
  logic [mxkeyb-1:0]  fit_key   [n_groups];
  logic [mxpatc-1:0]  fit_carry [n_groups];
  logic [mxoffsb-1:0] fit_offs  [n_groups];
  logic [mxbndb-1:0]  fit_bend  [n_groups];
  logic [mxqltb-1:0]  fit_qlt   [n_groups];

  // Buffer stage outputs
  logic               buf_strobe;
  logic [mxpatb-1:0]  buf_pat   [n_groups];
  logic [mxkeyb-1:0]  buf_key   [n_groups];
  logic [mxpatc-1:0]  buf_carry [n_groups];
  logic [mxoffsb-1:0] buf_offs  [n_groups];
  logic [mxbndb-1:0]  buf_bend  [n_groups];
  logic [mxqltb-1:0]  buf_qlt   [n_groups];

  //--------------------------------------------------------------------------
  // Three-stage pipeline, fit then buffer then best 1 of 7
  //--------------------------------------------------------------------------

  pattern_fit_lut i_pattern_fit_lut (.*);

  // Group masking happens here
  candidate_buffer i_candidate_buffer (.*);

  best_1of7_cclut #(
    .sort_on_quality (sort_on_quality)
  ) i_best_1of7_cclut (.*);

endmodule

//--- test/clct_sorter_checker.sv
`timescale 1ns/100ps

module clct_sorter_checker
  import clct_pkg::*;
(
  input logic                clock,
  input logic                reset,
  input logic                in_strobe,
  input logic                best_strobe,
  input logic [mxpatb-1:0]   best_pat,
  input logic [mxkeybx-1:0]  best_key,
  input logic [mxxkyb-1:0]   best_subkey,
  input logic [mxqltb-1:0]   best_qlt
);

  // Failed assertions so far, watched from the testbench
  int assert_errors = 0;

  //--------------------------------------------------------------------------
  // Latency
  //--------------------------------------------------------------------------

  // Each event comes out exactly three cycles later
  a_latency_fwd: assert property (@(posedge clock) disable iff (reset)
    in_strobe |-> ##3 best_strobe)
  else
  begin
    assert_errors++;
    $error("in_strobe without best_strobe three cycles later");
  end

  // No result without an event three cycles earlier
  a_latency_back: assert property (@(posedge clock) disable iff (reset)
    best_strobe |-> $past(in_strobe, 3))
  else
  begin
    assert_errors++;
    $error("best_strobe without a matching in_strobe");
  end

  //--------------------------------------------------------------------------
  // Output sanity
  //--------------------------------------------------------------------------

  // Subkey stays inside the section of its key
  a_subkey_section: assert property (@(posedge clock) disable iff (reset)
    best_strobe |-> (best_key[mxkeybx-1] ?
      (best_subkey >= sect1_min_subkey && best_subkey <= sect1_max_subkey) :
      (best_subkey <= sect0_max_subkey)))
  else
  begin
    assert_errors++;
    $error("best_subkey %0d outside section of key %0d", best_subkey, best_key);
  end

  // Empty pattern carries no quality
  a_empty_qlt: assert property (@(posedge clock) disable iff (reset)
    (best_strobe && best_pat[mxpatb-1 -: mxhitb] == '0) |-> best_qlt == '0)
  else
  begin
    assert_errors++;
    $error("best_qlt %0d with zero hit count", best_qlt);
  end

endmodule

bind clct_sorter clct_sorter_checker i_clct_sorter_checker (
  .clock       (clock),
  .reset       (reset),
  .in_strobe   (in_strobe),
  .best_strobe (best_strobe),
  .best_pat    (best_pat),
  .best_key    (best_key),
  .best_subkey (best_subkey),
  .best_qlt    (best_qlt)
);

//--- test/clct_sorter_model.svh
`ifndef CLCT_SORTER_MODEL_SVH
`define CLCT_SORTER_MODEL_SVH

// Expected result of one event
typedef struct packed {
  logic [mxpatb-1:0]  pat;
  logic [mxkeybx-1:0] key;
  logic [mxbndb-1:0]  bend;
  logic [mxpatc-1:0]  carry;
  logic [mxxkyb-1:0]  subkey;
  logic [mxqltb-1:0]  qlt;
} expect_t;

// Sum of the 2-bit positions from layer first to layer last
function automatic int pos_sum(input logic [mxpatc-1:0] c, input int first, input int last);
  int s;
  s = 0;
  for (int i = first; i <= last; i++)
    s += int'(c[2*i +: 2]);
  return s;
endfunction

// Offset is the centred sum, clipped to -8..7
function automatic int model_offs(input logic [mxpatc-1:0] c);
  int o;
  o = pos_sum(c, 0, 5) - 9;
  if (o < -8)
    o = -8;
  if (o > 7)
    o = 7;
  return o;
endfunction

// Eight per hit plus seven, less the spread; nothing for an empty pattern
function automatic int model_qlt(input logic [mxpatb-1:0] p, input logic [mxpatc-1:0] c);
  int hi;
  int lo;
  int v;
  hi = 0;
  lo = 3;
  for (int i = 0; i < 6; i++)
  begin
    v = int'(c[2*i +: 2]);
    hi = (v > hi) ? v : hi;
    lo = (v < lo) ? v : lo;
  end
  if (p[6:4] == 3'd0)
    return 0;
  return 8 * int'(p[6:4]) + 7 - (hi - lo);
endfunction

// Whole event through fit, masking, selection and subkey clamp
function automatic expect_t predict(input logic [mxpatb-1:0] p [n_groups],
                                    input logic [mxkeyb-1:0] k [n_groups],
                                    input logic [mxpatc-1:0] c [n_groups],
                                    input logic [n_groups-1:0] ena);
  int q [n_groups];
  int top;
  int w;
  int gkey;
  int sk;
  int mag;
  expect_t e;
  top = 0;
  for (int g = 0; g < n_groups; g++)
  begin
    q[g] = ena[g] ? model_qlt(p[g], c[g]) : 0;
    top = (q[g] > top) ? q[g] : top;
  end
  // First group holding the maximum
  w = 0;
  while (q[w] != top)
    w++;
  gkey = w * 32 + int'(k[w]);
  sk = 4 * gkey + model_offs(c[w]);
  if (gkey >= 128)
    sk = (sk < sect1_min_subkey) ? sect1_min_subkey :
         (sk > sect1_max_subkey) ? sect1_max_subkey : sk;
  else
    sk = (sk < 0) ? 0 : (sk > sect0_max_subkey) ? sect0_max_subkey : sk;
  mag = pos_sum(c[w], 3, 5) - pos_sum(c[w], 0, 2);
  mag = (mag < 0) ? -mag : mag;
  // Bend direction comes from the pattern before masking
  e.pat    = ena[w] ? p[w] : '0;
  e.key    = mxkeybx'(gkey);
  e.bend   = {p[w][0], 4'(mag)};
  e.carry  = c[w];
  e.subkey = mxxkyb'(sk);
  e.qlt    = mxqltb'(q[w]);
  return e;
endfunction

`endif

//--- test/clct_sorter_tb.sv
`timescale 1ns/100ps

module clct_sorter_tb
  import clct_pkg::*;
();

  `include "clct_sorter_model.svh"

  localparam int n_events       = 2000;
  localparam int timeout_cycles = n_events * 2 + 50;

  // Stimulus kinds
  localparam int mode_rand  = 0;
  localparam int mode_ties  = 1;
  localparam int mode_clamp = 2;
  localparam int mode_mask  = 3;

  logic                clock;
  logic                reset;
  logic                in_strobe;
  logic [n_groups-1:0] group_enable;
  logic [mxpatb-1:0]   pat   [n_groups];
  logic [mxkeyb-1:0]   key   [n_groups];
  logic [mxpatc-1:0]   carry [n_groups];
  logic                best_strobe;
  logic [mxpatb-1:0]   best_pat;
  logic [mxkeybx-1:0]  best_key;
  logic [mxbndb-1:0]   best_bend;
  logic [mxpatc-1:0]   best_carry;
  logic [mxxkyb-1:0]   best_subkey;
  logic [mxqltb-1:0]   best_qlt;

  // Next event, and the event still waiting for its enable
  logic [mxpatb-1:0]   st_pat     [n_groups];
  logic [mxkeyb-1:0]   st_key     [n_groups];
  logic [mxpatc-1:0]   st_carry   [n_groups];
  logic [mxpatb-1:0]   pend_pat   [n_groups];
  logic [mxkeyb-1:0]   pend_key   [n_groups];
  logic [mxpatc-1:0]   pend_carry [n_groups];
  logic                pend_valid = 1'b0;

  expect_t             exp_q [$];
  logic [31:0]         rng_state = 32'h810a;
  int                  cycle_count = 0;

  clct_sorter #(.sort_on_quality(1)) i_clct_sorter (.*);

  initial
  begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  //--------------------------------------------------------------------------
  // Error reporting and compare tasks
  //--------------------------------------------------------------------------

  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic report_value(input string name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    $display("FAIL %0t %s expected %0h got %0h", $time, name, exp_v, act_v);
    abort_run();
  endtask

  task automatic check_pat(input logic [mxpatb-1:0] exp_v, input logic [mxpatb-1:0] act_v);
    if (act_v !== exp_v)
      report_value("best_pat", exp_v, act_v);
  endtask

  task automatic check_key(input logic [mxkeybx-1:0] exp_v, input logic [mxkeybx-1:0] act_v);
    if (act_v !== exp_v)
      report_value("best_key", exp_v, act_v);
  endtask

  task automatic check_bend(input logic [mxbndb-1:0] exp_v, input logic [mxbndb-1:0] act_v);
    if (act_v !== exp_v)
      report_value("best_bend", exp_v, act_v);
  endtask

  task automatic check_carry(input logic [mxpatc-1:0] exp_v, input logic [mxpatc-1:0] act_v);
    if (act_v !== exp_v)
      report_value("best_carry", exp_v, act_v);
  endtask

  task automatic check_subkey(input logic [mxxkyb-1:0] exp_v, input logic [mxxkyb-1:0] act_v);
    if (act_v !== exp_v)
      report_value("best_subkey", exp_v, act_v);
  endtask

  task automatic check_qlt(input logic [mxqltb-1:0] exp_v, input logic [mxqltb-1:0] act_v);
    if (act_v !== exp_v)
      report_value("best_qlt", exp_v, act_v);
  endtask

  // Scoreboard, sampled mid-cycle where outputs are settled
  always @(negedge clock)
  begin
    expect_t e;
    if (!reset && best_strobe)
    begin
      if (exp_q.size() == 0)
      begin
        $display("best_strobe at %0t with no event outstanding", $time);
        abort_run();
      end
      else
      begin
        e = exp_q.pop_front();
        check_pat(e.pat, best_pat);
        check_key(e.key, best_key);
        check_bend(e.bend, best_bend);
        check_carry(e.carry, best_carry);
        check_subkey(e.subkey, best_subkey);
        check_qlt(e.qlt, best_qlt);
      end
    end
  end

  // Watchdog, also picks up failed checker assertions
  always @(posedge clock)
  begin
    cycle_count++;
    if (i_clct_sorter.i_clct_sorter_checker.assert_errors != 0)
    begin
      $display("An assertion in the bound checker failed");
      abort_run();
    end
    else if (cycle_count > timeout_cycles)
    begin
      $display("Run did not finish within %0d cycles", timeout_cycles);
      abort_run();
    end
  end

  //--------------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------------

  function automatic logic [31:0] xorshift32();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  task automatic gen_event(input int mode);
    logic [31:0] r;
    int          tg;
    for (int g = 0; g < n_groups; g++)
    begin
      r = xorshift32();
      st_pat[g]   = {3'(r % 7), r[6:3]};
      st_key[g]   = r[11:7];
      st_carry[g] = r[23:12];
      // Flat codes give zero spread, so quality is 47 or 55
      if (mode == mode_ties)
      begin
        st_pat[g][6:4] = 3'(5 + r[24]);
        st_carry[g]    = {6{r[26:25]}};
      end
      if (mode == mode_clamp && st_pat[g][6:4] == 3'd6)
        st_pat[g][6:4] = 3'd5;
    end
    r = xorshift32();
    // Winner pinned at key 0, 127, 128 or 223 with an extreme offset
    if (mode == mode_clamp)
    begin
      tg = (r[1:0] == 2'd0) ? 0 : (r[1:0] == 2'd1) ? 3 : (r[1:0] == 2'd2) ? 4 : 6;
      st_pat[tg][6:4] = 3'd6;
      st_key[tg]      = (tg == 0 || tg == 4) ? 5'(r[2]) : 5'(31 - r[2]);
      st_carry[tg]    = {6{r[3], r[3]}};
    end
    // Occasional fully empty event
    if (mode == mode_mask && r[6:4] == 3'd0)
    begin
      for (int g = 0; g < n_groups; g++)
        st_pat[g][6:4] = 3'd0;
    end
  endtask

  function automatic logic [n_groups-1:0] pick_enable(input int mode);
    logic [31:0] r;
    r = xorshift32();
    if (mode == mode_mask)
      return (r[2:0] == 3'd0) ? '0 : n_groups'(r[9:3] & r[16:10]);
    if (mode == mode_rand)
      return n_groups'(r[6:0] | r[13:7]);
    return '1;
  endfunction

  // Enable driven now belongs to the event strobed one cycle earlier
  task automatic drive_cycle(input logic strobe, input logic [n_groups-1:0] ena);
    @(posedge clock);
    #1;
    if (pend_valid)
      exp_q.push_back(predict(pend_pat, pend_key, pend_carry, ena));
    group_enable = ena;
    in_strobe    = strobe;
    pat          = st_pat;
    key          = st_key;
    carry        = st_carry;
    pend_valid   = strobe;
    pend_pat     = st_pat;
    pend_key     = st_key;
    pend_carry   = st_carry;
  endtask

  task automatic run_phase(input int mode, input int n_ev, input int density);
    int   issued;
    logic strobe;
    issued = 0;
    while (issued < n_ev)
    begin
      strobe = (xorshift32() % 100) < density;
      gen_event(mode);
      drive_cycle(strobe, pick_enable(mode));
      if (strobe)
        issued++;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) drive_cycle(1'b0, pick_enable(mode_rand));
  endtask

  // Drops whatever is in flight
  task automatic reset_mid_stream();
    @(posedge clock);
    #1;
    reset      = 1'b1;
    in_strobe  = 1'b0;
    pend_valid = 1'b0;
    exp_q.delete();
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
  endtask

  initial
  begin
    reset        = 1'b1;
    in_strobe    = 1'b0;
    group_enable = '1;
    pat          = '{default: '0};
    key          = '{default: '0};
    carry        = '{default: '0};
    st_pat       = '{default: '0};
    st_key       = '{default: '0};
    st_carry     = '{default: '0};
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    // Nothing may come out before the first event
    idle(6);
    run_phase(mode_rand, 800, 70);
    run_phase(mode_ties, 300, 100);
    run_phase(mode_clamp, 300, 100);
    run_phase(mode_mask, 300, 70);
    reset_mid_stream();
    idle(8);
    run_phase(mode_rand, 300, 70);
    idle(6);
    // A missing result leaves the queue full until the watchdog fires
    while (exp_q.size() != 0)
      @(posedge clock);
    $display("sim passed");
    $finish;
  end

endmodule

//--- clct_sorter.f
+incdir+test
logic/clct_pkg.sv
logic/pattern_fit_lut.sv
logic/candidate_buffer.sv
logic/best_1of7_cclut.sv
logic/clct_sorter.sv
test/clct_sorter_checker.sv
test/clct_sorter_tb.sv
